//--- logic/cachePkg.sv
// cache package: geometry constants, CPU address decode and sequencer states
package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// cache geometry
	//////////////////////////////////////////////////////////////////////
	localparam int NumWays = 4;							// ways per set, fixed by the LRU tree
	localparam int NumSets = 8;							// sets selected by the index field
	localparam int LineWords = 8;						// 16 bit words per line
	localparam int TagWidth = 25;						// upper address bits kept per line
	localparam int LruWidth = 3;						// tree bits for four ways
	localparam int CasLatency = 2;						// clocks from CAS to first burst word

	// field view of a 68k byte address
	typedef struct packed {
		logic [TagWidth-1:0] tag;						// compared against the tag store
		logic [2:0] index;								// set select
		logic [2:0] word;								// word within the line
		logic byteSel;									// byte lane, unused by word reads
	} addrFieldsT;

	// one address word, read flat by the DRAM side or split by the cache
	typedef union packed {
		logic [31:0] flat;
		addrFieldsT fields;
	} cpuAddrT;

	//////////////////////////////////////////////////////////////////////
	// sequencer states
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		Reset,											// clear burst counter
		Invalidate,										// sweep all sets clearing valid bits
		Idle,											// wait for a 68k DRAM access
		CheckHit,										// tag compare on a read
		WaitCacheRead,									// hit data held until AS rises
		WaitCas,										// wait for a read CAS, not a refresh
		CasDelay1,										// first CAS latency clock
		CasDelay2,										// second CAS latency clock
		BurstFill,										// one line word per clock into the victim
		EndBurstFill,									// line filled, answer the 68k
		WriteDram										// write through, DTACK from DRAM
	} seqStateT;

endpackage

//--- logic/cacheSequencer.sv
`timescale 1ns/10ps
// cache sequencer: request FSM, burst counter and control of the stores and both buses
module cacheSequencer import cachePkg::*; #(
	parameter int NumWays,
	parameter int NumSets,
	parameter int LineWords
) (
	input logic Clock,
	input logic Reset_L,
	input logic dramSelect,
	input cpuAddrT addressIn,
	input logic [15:0] dataIn,
	input logic udsL,
	input logic ldsL,
	input logic weL,
	input logic asL,
	input logic dramDtackL,
	input logic casL,
	input logic rasL,
	input logic [NumWays-1:0] validHit,					// one bit per way, valid and tag equal
	input logic [LruWidth-1:0] lruRead,
	input logic [$clog2(NumWays)-1:0] victimWay,
	input logic [LruWidth-1:0] hitLruNext,
	input logic [LruWidth-1:0] fillLruNext,
	output logic dtackL,
	output logic [31:0] dramAddress,
	output logic [15:0] dramDataOut,
	output logic dramUdsL,
	output logic dramLdsL,
	output logic dramWeL,
	output logic dramAsL,
	output logic dramSelectL,
	output logic [$clog2(NumSets)-1:0] index,
	output logic [$clog2(LineWords)-1:0] wordAddress,
	output logic [TagWidth-1:0] tagData,
	output logic validData,
	output logic [NumWays-1:0] tagWeL,
	output logic [NumWays-1:0] validWeL,
	output logic [NumWays-1:0] dataWeL,
	output logic [LruWidth-1:0] lruData,
	output logic lruWeL,
	output logic [LruWidth-1:0] lruBits,
	output logic [$clog2(NumWays)-1:0] hitWay
);

	localparam int WayBits = $clog2(NumWays);
	localparam int IndexBits = $clog2(NumSets);
	localparam int WordBits = $clog2(LineWords);
	localparam int CountWidth = $clog2((NumSets > LineWords) ? NumSets : LineWords) + 1;

	seqStateT state;
	seqStateT nextState;
	logic [CountWidth-1:0] burstCount;					// fill word number, or set during sweep
	logic countClear;
	logic [WayBits-1:0] victimReg;						// way being refilled
	logic victimLoad;
	logic lruLoad;
	logic accept;										// 68k DRAM cycle seen in Idle
	logic anyHit;
	logic [WayBits-1:0] hitEncoded;

	assign accept = !asL && dramSelect;
	assign anyHit = |validHit;

	always_comb begin
		hitEncoded = '0;
		for (int w = 0; w < NumWays; w++) begin
			if (validHit[w])
				hitEncoded = WayBits'(w);				// at most one way can match
		end
	end

	//////////////////////////////////////////////////////////////////////
	// state, counter and latched request data
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= Reset;
			burstCount <= '0;
			victimReg <= '0;
			lruBits <= '0;
		end else begin
			state <= nextState;
			if (countClear)
				burstCount <= '0;
			else
				burstCount <= burstCount + 1'b1;		// free running, wraps while idle
			if (victimLoad)
				victimReg <= victimWay;					// taken on a read miss
			if (lruLoad)
				lruBits <= lruRead;						// set's tree at request acceptance
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		countClear = 1'b0;
		victimLoad = 1'b0;
		lruLoad = 1'b0;
		dtackL = 1'b1;									// no answer until ready
		dramSelectL = 1'b1;								// DRAM only cycled on miss or write
		dramAddress = {addressIn.fields.tag, addressIn.fields.index, 4'b0000};	// line start
		dramDataOut = dataIn;
		dramUdsL = udsL;
		dramLdsL = ldsL;
		dramWeL = weL;
		dramAsL = asL;
		index = addressIn.fields.index;
		wordAddress = addressIn.fields.word;
		tagData = addressIn.fields.tag;
		validData = 1'b0;
		tagWeL = '1;
		validWeL = '1;
		dataWeL = '1;
		lruData = '0;
		lruWeL = 1'b1;
		hitWay = hitEncoded;							// read way follows the tag match

		case (state)
			Reset: begin
				countClear = 1'b1;						// sweep starts at set 0
				nextState = Invalidate;
			end
			Invalidate: begin
				if (burstCount == CountWidth'(NumSets)) begin
					nextState = Idle;
				end else begin
					index = burstCount[IndexBits-1:0];
					tagData = '0;
					tagWeL = '0;						// every way of the set at once
					validWeL = '0;
					lruWeL = 1'b0;						// tree back to way 0
				end
			end
			Idle: begin
				if (accept) begin
					lruLoad = 1'b1;
					if (weL) begin
						dramUdsL = 1'b0;				// line reads are always full words
						dramLdsL = 1'b0;
						nextState = CheckHit;
					end else begin
						validWeL = ~validHit;			// drop a stale copy of the written line
						nextState = WriteDram;
					end
				end
			end
			CheckHit: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				if (anyHit) begin
					dtackL = 1'b0;						// cache word on dataOut now
					lruData = hitLruNext;
					lruWeL = 1'b0;
					nextState = WaitCacheRead;
				end else begin
					dramSelectL = 1'b0;					// start the burst read
					victimLoad = 1'b1;
					lruData = fillLruNext;
					lruWeL = 1'b0;
					nextState = WaitCas;
				end
			end
			WaitCacheRead: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dtackL = 1'b0;
				if (asL)
					nextState = Idle;					// 68k ended the cycle
			end
			WaitCas: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dramSelectL = 1'b0;
				validData = 1'b1;
				tagWeL = ~(NumWays'(1) << victimReg);	// claim the victim way
				validWeL = ~(NumWays'(1) << victimReg);
				if (!casL && rasL)
					nextState = CasDelay1;				// read CAS, refresh has RAS low too
			end
			CasDelay1: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dramSelectL = 1'b0;
				nextState = CasDelay2;
			end
			CasDelay2: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dramSelectL = 1'b0;
				countClear = 1'b1;						// first fill word is word 0
				nextState = BurstFill;
			end
			BurstFill: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dramSelectL = 1'b0;
				wordAddress = burstCount[WordBits-1:0];
				dataWeL = ~(NumWays'(1) << victimReg);
				if (burstCount == CountWidth'(LineWords - 1))
					nextState = EndBurstFill;			// last word written this clock
			end
			EndBurstFill: begin
				dramUdsL = 1'b0;
				dramLdsL = 1'b0;
				dtackL = 1'b0;
				hitWay = victimReg;						// read back from the new line
				if (asL)
					nextState = Idle;
			end
			WriteDram: begin
				dramAddress = addressIn.flat;			// full byte address for writes
				dramSelectL = 1'b0;
				dtackL = dramDtackL;					// DRAM paces the write
				if (asL)
					nextState = Idle;
			end
			default: nextState = Reset;
		endcase
	end

endmodule

//--- logic/cacheTop.sv
`timescale 1ns/10ps
// cache top: four way read cache between the 68k bus and the DRAM controller
module cacheTop import cachePkg::*; #(
	parameter int NumWays = cachePkg::NumWays,
	parameter int NumSets = cachePkg::NumSets,
	parameter int LineWords = cachePkg::LineWords
) (
	input logic Clock,
	input logic Reset_L,
	// 68k side
	input logic dramSelect,								// high when the 68k addresses DRAM
	input cpuAddrT addressIn,
	input logic [15:0] dataIn,
	input logic udsL,
	input logic ldsL,
	input logic weL,
	input logic asL,
	output logic [15:0] dataOut,
	output logic dtackL,
	// DRAM controller side
	input logic [15:0] dramDataIn,
	input logic dramDtackL,
	input logic casL,
	input logic rasL,
	output logic [31:0] dramAddress,
	output logic [15:0] dramDataOut,
	output logic dramUdsL,
	output logic dramLdsL,
	output logic dramWeL,
	output logic dramAsL,
	output logic dramSelectL
);

	logic [$clog2(NumSets)-1:0] index;					// set under access or sweep
	logic [$clog2(LineWords)-1:0] wordAddress;			// word within the line
	logic [TagWidth-1:0] tagData;
	logic validData;
	logic [NumWays-1:0] tagWeL;
	logic [NumWays-1:0] validWeL;
	logic [NumWays-1:0] dataWeL;
	logic [LruWidth-1:0] lruData;
	logic lruWeL;
	logic [LruWidth-1:0] lruBits;						// sequencer's copy of the set's tree
	logic [$clog2(NumWays)-1:0] hitWay;
	logic [NumWays-1:0] validHit;
	logic [LruWidth-1:0] lruRead;
	logic [$clog2(NumWays)-1:0] victimWay;
	logic [LruWidth-1:0] hitLruNext;
	logic [LruWidth-1:0] fillLruNext;
	logic [15:0] cacheData;								// word read from the selected way

	cacheSequencer #(
		.NumWays(NumWays),
		.NumSets(NumSets),
		.LineWords(LineWords)
	) sequencer (
		.Clock(Clock), .Reset_L(Reset_L),
		.dramSelect(dramSelect), .addressIn(addressIn), .dataIn(dataIn),
		.udsL(udsL), .ldsL(ldsL), .weL(weL), .asL(asL),
		.dramDtackL(dramDtackL), .casL(casL), .rasL(rasL),
		.validHit(validHit), .lruRead(lruRead), .victimWay(victimWay),
		.hitLruNext(hitLruNext), .fillLruNext(fillLruNext),
		.dtackL(dtackL), .dramAddress(dramAddress), .dramDataOut(dramDataOut),
		.dramUdsL(dramUdsL), .dramLdsL(dramLdsL), .dramWeL(dramWeL),
		.dramAsL(dramAsL), .dramSelectL(dramSelectL),
		.index(index), .wordAddress(wordAddress), .tagData(tagData),
		.validData(validData), .tagWeL(tagWeL), .validWeL(validWeL),
		.dataWeL(dataWeL), .lruData(lruData), .lruWeL(lruWeL),
		.lruBits(lruBits), .hitWay(hitWay)
	);

	plruPolicy replacement (
		.lruBits(lruBits), .hitWay(hitWay), .victimWay(victimWay),
		.hitLruNext(hitLruNext), .fillLruNext(fillLruNext)
	);

	tagStore #(
		.NumWays(NumWays),
		.NumSets(NumSets)
	) tags (
		.Clock(Clock), .index(index), .tagData(tagData), .validData(validData),
		.tagWeL(tagWeL), .validWeL(validWeL), .lruData(lruData), .lruWeL(lruWeL),
		.compareTag(addressIn.fields.tag), .validHit(validHit), .lruRead(lruRead)
	);

	dataStore #(
		.NumWays(NumWays),
		.NumSets(NumSets),
		.LineWords(LineWords)
	) lines (
		.Clock(Clock), .index(index), .wordAddress(wordAddress), .dataWeL(dataWeL),
		.wordIn(dramDataIn), .hitWay(hitWay), .wordOut(cacheData)
	);

	assign dataOut = cacheData;							// read data straight from the line store

endmodule

//--- logic/dataStore.sv
`timescale 1ns/10ps
// data store: line words per way, filled from the DRAM burst and read by word address
module dataStore #(
	parameter int NumWays,
	parameter int NumSets,
	parameter int LineWords
) (
	input logic Clock,
	input logic [$clog2(NumSets)-1:0] index,
	input logic [$clog2(LineWords)-1:0] wordAddress,
	input logic [NumWays-1:0] dataWeL,					// victim way strobe during fill
	input logic [15:0] wordIn,							// burst word from DRAM
	input logic [$clog2(NumWays)-1:0] hitWay,			// way to read, hit or just filled
	output logic [15:0] wordOut
);

	logic [15:0] lineMem [NumWays][NumSets][LineWords];

	always_ff @(posedge Clock) begin
		for (int w = 0; w < NumWays; w++) begin
			if (!dataWeL[w])
				lineMem[w][index][wordAddress] <= wordIn;
		end
	end

	// read is asynchronous so the word is ready with DTACK
	assign wordOut = lineMem[hitWay][index][wordAddress];

endmodule

//--- logic/plruPolicy.sv
`timescale 1ns/10ps
// tree pseudo-LRU: victim choice and tree update for four ways
module plruPolicy import cachePkg::*; (
	input logic [LruWidth-1:0] lruBits,					// bit 0 pair, bit 1 ways 0/1, bit 2 ways 2/3
	input logic [1:0] hitWay,
	output logic [1:0] victimWay,
	output logic [LruWidth-1:0] hitLruNext,
	output logic [LruWidth-1:0] fillLruNext
);

	// point the tree away from a way just used
	function automatic logic [LruWidth-1:0] touch(input logic [LruWidth-1:0] bits,
			input logic [1:0] way);
		logic [LruWidth-1:0] next;
		next = bits;
		next[0] = ~way[1];								// other pair goes next
		if (way[1])
			next[2] = ~way[0];							// other way of pair 2/3
		else
			next[1] = ~way[0];							// other way of pair 0/1
		return next;
	endfunction

	always_comb begin
		if (lruBits[0])
			victimWay = {1'b1, lruBits[2]};
		else
			victimWay = {1'b0, lruBits[1]};
	end

	assign hitLruNext = touch(lruBits, hitWay);
	assign fillLruNext = touch(lruBits, victimWay);		// fill counts as a use of the victim

endmodule

//--- logic/tagStore.sv
`timescale 1ns/10ps
// tag store: per way tags and valid bits, per set LRU tree, and the tag compare
module tagStore import cachePkg::*; #(
	parameter int NumWays,
	parameter int NumSets
) (
	input logic Clock,
	input logic [$clog2(NumSets)-1:0] index,
	input logic [TagWidth-1:0] tagData,
	input logic validData,
	input logic [NumWays-1:0] tagWeL,
	input logic [NumWays-1:0] validWeL,
	input logic [LruWidth-1:0] lruData,
	input logic lruWeL,
	input logic [TagWidth-1:0] compareTag,				// tag field of the current address
	output logic [NumWays-1:0] validHit,
	output logic [LruWidth-1:0] lruRead
);

	logic [TagWidth-1:0] tagMem [NumWays][NumSets];
	logic validMem [NumWays][NumSets];
	logic [LruWidth-1:0] lruMem [NumSets];				// one tree per set, shared by the ways

	//////////////////////////////////////////////////////////////////////
	// writes on the clock edge
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock) begin
		for (int w = 0; w < NumWays; w++) begin
			if (!tagWeL[w])
				tagMem[w][index] <= tagData;
			if (!validWeL[w])
				validMem[w][index] <= validData;		// cleared on sweep or write through
		end
	end

	always_ff @(posedge Clock) begin
		if (!lruWeL)
			lruMem[index] <= lruData;
	end

	//////////////////////////////////////////////////////////////////////
	// combinational lookup
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < NumWays; w++) begin
			validHit[w] = validMem[w][index] && (tagMem[w][index] == compareTag);
		end
	end

	assign lruRead = lruMem[index];

endmodule

//--- sim.f
logic/cachePkg.sv
logic/plruPolicy.sv
logic/tagStore.sv
logic/dataStore.sv
logic/cacheSequencer.sv
logic/cacheTop.sv
testbench/dramModel.sv
testbench/cacheTb.sv

//--- testbench/cacheTb.sv
`timescale 1ns/10ps
// cache testbench: 68k read and write cycles against a DRAM model, checked by assertions
module cacheTb import cachePkg::*; ();

	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 16;
	localparam int RandomLines = 6;
	localparam int NumRequests = 1 + 2 * RandomLines + 3 + 8;	// all bus cycles below
	localparam int CyclesPerRequest = 200;
	localparam logic [2:0] EvictSet = 3'd5;

	logic Clock;
	logic Reset_L;
	logic dramSelect;
	logic [31:0] addressIn;
	logic [15:0] dataIn;
	logic udsL, ldsL, weL, asL;
	logic [15:0] dataOut;
	logic dtackL;
	logic [15:0] dramDataIn;
	logic dramDtackL, casL, rasL;
	logic [31:0] dramAddress;
	logic [15:0] dramDataOut;
	logic dramUdsL, dramLdsL, dramWeL, dramAsL, dramSelectL;

	string testName;
	logic startupDone;									// reset sweep over
	logic readArmed, expectHit, expectMiss, writeArmed;
	logic [15:0] expectData;
	logic [31:0] expectAddress;
	logic [15:0] expectWrite;
	logic [1:0] expectStrobes;							// UDS and LDS of the write
	logic haveWritten;
	logic [31:0] writtenAddress;
	logic [15:0] writtenWord;

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	cacheTop DUT (
		.Clock(Clock), .Reset_L(Reset_L), .dramSelect(dramSelect), .addressIn(addressIn),
		.dataIn(dataIn), .udsL(udsL), .ldsL(ldsL), .weL(weL), .asL(asL),
		.dataOut(dataOut), .dtackL(dtackL), .dramDataIn(dramDataIn),
		.dramDtackL(dramDtackL), .casL(casL), .rasL(rasL), .dramAddress(dramAddress),
		.dramDataOut(dramDataOut), .dramUdsL(dramUdsL), .dramLdsL(dramLdsL),
		.dramWeL(dramWeL), .dramAsL(dramAsL), .dramSelectL(dramSelectL)
	);

	dramModel dram (
		.Clock(Clock), .dramAddress(dramAddress), .dramDataOut(dramDataOut),
		.dramUdsL(dramUdsL), .dramLdsL(dramLdsL), .dramWeL(dramWeL),
		.dramSelectL(dramSelectL), .dramDataIn(dramDataIn), .dramDtackL(dramDtackL),
		.casL(casL), .rasL(rasL)
	);

	task automatic reportFailure(input string message);
		$display("%s", message);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic valueMismatch(input logic [31:0] expected, input logic [31:0] actual);
		reportFailure($sformatf("[FAIL] %s: expected %0h, actual %0h", testName, expected, actual));
	endtask

	// word the 68k should see: the written word, else line address xor word number
	function automatic logic [15:0] expectedWord(input logic [31:0] address);
		logic [31:0] line;
		line = {address[31:4], 4'b0000};
		if (haveWritten && writtenAddress[31:1] == address[31:1])
			return writtenWord;
		return line[15:0] ^ {13'b0, address[3:1]};
	endfunction

	function automatic logic [31:0] evictAddress(input logic [TagWidth-1:0] tag);
		return {tag, EvictSet, 3'd2, 1'b0};				// word 2 of the shared set
	endfunction

	// wait for DTACK, then close the cycle on the next falling edge
	task automatic endCycle();
		do
			@(posedge Clock);
		while (dtackL);
		@(negedge Clock);
		asL = 1'b1;										// address and strobes left as they are
		dramSelect = 1'b0;
		readArmed = 1'b0;
		expectHit = 1'b0;
		expectMiss = 1'b0;
		writeArmed = 1'b0;
	endtask

	task automatic readWord(input string name, input logic [31:0] address, input logic hit);
		@(negedge Clock);
		testName = name;
		expectData = expectedWord(address);
		expectHit = hit;
		expectMiss = !hit;
		readArmed = 1'b1;
		addressIn = address;
		weL = 1'b1;
		udsL = 1'b0;
		ldsL = 1'b0;
		dramSelect = 1'b1;
		asL = 1'b0;
		endCycle();
	endtask

	task automatic writeWord(input string name, input logic [31:0] address,
			input logic [15:0] data, input logic upperL, input logic lowerL);
		logic [15:0] merged;
		merged = expectedWord(address);					// lanes not strobed keep their word
		if (!upperL)
			merged[15:8] = data[15:8];
		if (!lowerL)
			merged[7:0] = data[7:0];
		@(negedge Clock);
		testName = name;
		expectAddress = address;
		expectWrite = data;
		expectStrobes = {upperL, lowerL};
		writeArmed = 1'b1;
		haveWritten = 1'b1;
		writtenAddress = address;
		writtenWord = merged;
		addressIn = address;
		dataIn = data;
		weL = 1'b0;
		udsL = upperL;
		ldsL = lowerL;
		dramSelect = 1'b1;
		asL = 1'b0;
		endCycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////
	startupQuiet: assert property (@(posedge Clock) !startupDone |-> dtackL && dramSelectL)
		else reportFailure("dtackL or dramSelectL went low during reset or invalidation");
	readData: assert property (@(posedge Clock) readArmed && !dtackL |-> dataOut == expectData)
		else valueMismatch(32'(expectData), 32'($sampled(dataOut)));
	hitAnswer: assert property (@(posedge Clock) expectHit && $fell(asL) |=> !dtackL)
		else reportFailure($sformatf("%s: dtackL not low one cycle after a hit", testName));
	hitNoDram: assert property (@(posedge Clock) expectHit |-> dramSelectL)
		else reportFailure($sformatf("%s: a read hit selected DRAM", testName));
	missSelect: assert property (@(posedge Clock) expectMiss && $fell(asL) |=> !dramSelectL)
		else reportFailure($sformatf("%s: a read miss did not select DRAM", testName));
	writeSelect: assert property (@(posedge Clock) writeArmed && $fell(asL) |=> !dramSelectL)
		else reportFailure($sformatf("%s: a write did not select DRAM", testName));
	writeAddr: assert property (@(posedge Clock)
			writeArmed && !dramSelectL |-> dramAddress == expectAddress)
		else valueMismatch(expectAddress, $sampled(dramAddress));
	writeData: assert property (@(posedge Clock)
			writeArmed && !dramSelectL |-> dramDataOut == expectWrite)
		else valueMismatch(32'(expectWrite), 32'($sampled(dramDataOut)));
	writeStrobes: assert property (@(posedge Clock)
			writeArmed && !dramSelectL |->
			{dramUdsL, dramLdsL, dramWeL, dramAsL} == {expectStrobes, 2'b00})
		else valueMismatch(32'({expectStrobes, 2'b00}),
			32'($sampled({dramUdsL, dramLdsL, dramWeL, dramAsL})));
	writeDtack: assert property (@(posedge Clock)
			writeArmed && !dramSelectL |-> dtackL == dramDtackL)
		else valueMismatch(32'($sampled(dramDtackL)), 32'($sampled(dtackL)));

	initial begin
		repeat (ResetCycles + NumSets + 3 + CyclesPerRequest * NumRequests) @(posedge Clock);
		reportFailure("watchdog: the bus cycles did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] address;
		logic [TagWidth-1:0] tags [5];
		void'($urandom(32'hf032_8ad7));
		Reset_L = 1'b0;
		dramSelect = 1'b0;
		addressIn = '0;
		dataIn = '0;
		udsL = 1'b1;
		ldsL = 1'b1;
		weL = 1'b1;
		asL = 1'b1;
		startupDone = 1'b0;
		readArmed = 1'b0;
		expectHit = 1'b0;
		expectMiss = 1'b0;
		writeArmed = 1'b0;
		expectStrobes = 2'b00;
		haveWritten = 1'b0;
		testName = "reset";
		tags = '{25'h100_0001, 25'h100_0002, 25'h100_0003, 25'h100_0004, 25'h100_0005};
		repeat (ResetCycles) @(negedge Clock);
		Reset_L = 1'b1;
		repeat (NumSets + 3) @(posedge Clock);			// sweep done, sequencer idle
		@(negedge Clock);
		startupDone = 1'b1;

		readWord("first read misses", 32'h0000_0000, 1'b0);
		for (int i = 0; i < RandomLines; i++) begin
			address = $urandom;
			address[0] = 1'b0;
			readWord("random line miss", address, 1'b0);
			address[3:1] = 3'($urandom);				// other word, same line
			readWord("same line hit", address, 1'b1);
		end

		address = {25'h0ab_cdef, 3'd3, 3'd5, 1'b0};
		readWord("line cached before write", address, 1'b0);
		writeWord("write through", address, 16'h5a3c, 1'b0, 1'b1);	// upper byte only
		readWord("read after write misses", address, 1'b0);

		// A, B, C, D fill the set; A is used again, so E replaces B
		for (int t = 0; t < 4; t++)
			readWord("set filled with A to D", evictAddress(tags[t]), 1'b0);
		readWord("A hits before E", evictAddress(tags[0]), 1'b1);
		readWord("E fills the set", evictAddress(tags[4]), 1'b0);
		readWord("B evicted by E", evictAddress(tags[1]), 1'b0);
		readWord("A kept after E", evictAddress(tags[0]), 1'b1);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- testbench/dramModel.sv
`timescale 1ns/10ps
// DRAM controller model: burst reads after a random CAS delay, writes answered with DTACK
module dramModel import cachePkg::*; #(
	parameter int MaxWrites = 16
) (
	input logic Clock,
	input logic [31:0] dramAddress,
	input logic [15:0] dramDataOut,
	input logic dramUdsL,
	input logic dramLdsL,
	input logic dramWeL,
	input logic dramSelectL,
	output logic [15:0] dramDataIn,
	output logic dramDtackL,
	output logic casL,
	output logic rasL
);

	logic [31:0] writeAddress [MaxWrites];				// even byte address of each write
	logic [15:0] writeData [MaxWrites];
	int writeCount;

	// stored word: the last write to it, else the line address rule
	function automatic logic [15:0] memoryWord(input logic [31:0] byteAddress);
		logic [31:0] line;
		logic [15:0] word;
		line = {byteAddress[31:4], 4'b0000};
		word = line[15:0] ^ {13'b0, byteAddress[3:1]};	// line address xor word number
		for (int i = 0; i < writeCount; i++) begin
			if (writeAddress[i] == {byteAddress[31:1], 1'b0})
				word = writeData[i];					// later writes win
		end
		return word;
	endfunction

	// merge a written word into the store by byte strobe
	task automatic storeWrite(input logic [31:0] byteAddress, input logic [15:0] data,
			input logic upperL, input logic lowerL);
		logic [15:0] merged;
		merged = memoryWord(byteAddress);
		if (!upperL)
			merged[15:8] = data[15:8];
		if (!lowerL)
			merged[7:0] = data[7:0];
		if (writeCount < MaxWrites) begin
			writeAddress[writeCount] = {byteAddress[31:1], 1'b0};
			writeData[writeCount] = merged;
			writeCount++;
		end
	endtask

	initial begin
		int delay;
		logic [31:0] line;
		dramDataIn = '0;
		dramDtackL = 1'b1;
		casL = 1'b1;
		rasL = 1'b1;
		writeCount = 0;
		forever begin
			@(negedge Clock);
			if (!dramSelectL && dramWeL) begin
				line = dramAddress;						// line start from the sequencer
				delay = 1 + int'($urandom % 6);
				repeat (delay) begin
					@(negedge Clock);
					if ($urandom % 4 == 0) begin
						casL = 1'b0;					// refresh cycle, must be ignored
						rasL = 1'b0;
					end else begin
						casL = 1'b1;
						rasL = 1'b1;
					end
				end
				@(negedge Clock);
				casL = 1'b0;							// read CAS, RAS stays high
				rasL = 1'b1;
				@(negedge Clock);
				casL = 1'b1;
				repeat (CasLatency - 1) @(negedge Clock);
				for (int n = 0; n < LineWords; n++) begin
					@(negedge Clock);
					dramDataIn = memoryWord(line + 32'(2 * n));	// one word per clock
				end
			end else if (!dramSelectL) begin
				storeWrite(dramAddress, dramDataOut, dramUdsL, dramLdsL);
				repeat (1 + int'($urandom % 3)) @(negedge Clock);
				dramDtackL = 1'b0;
				while (!dramSelectL)
					@(negedge Clock);					// hold until the cycle ends
				dramDtackL = 1'b1;
			end
		end
	end

endmodule
